// File: design/uart_pkg.sv
package uart_pkg;

  // Channel count and its index width
  localparam int NUM_CH = 4;
  localparam int CH_W   = $clog2(NUM_CH);

  // Serial bit timing in clk cycles, any even value of 8 or more works
  localparam int CLKS_PER_BIT = 16;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;  // Start edge to middle of start bit
  localparam int TIC_W        = $clog2(CLKS_PER_BIT + 1);

  localparam int SYNC_STAGES = 2;  // Synchronizer depth

  typedef logic [7:0]       byte_t;     // One received data byte
  typedef logic [CH_W-1:0]  ch_idx_t;   // Channel number
  typedef logic [2:0]       bit_cnt_t;  // Data bit 0..7
  typedef logic [TIC_W-1:0] tic_cnt_t;  // Bit timer

  // Receiver FSM
  typedef enum logic [2:0] {
    IDLE,   // Line idle, waiting for start edge
    START,  // Confirm start bit at half a bit
    DATA,   // Eight data samples, LSB first
    STOP,   // Stop bit sample
    DONE    // One cycle done pulse
  } rx_state_t;

  // One receiver's result
  typedef struct packed {
    byte_t data;
    logic  ferr;  // Stop bit sampled low
  } rx_result_t;

  // One collected event
  typedef struct packed {
    ch_idx_t ch;
    byte_t   data;
    logic    ferr;
  } rx_event_t;

endpackage

// File: design/rx_sync.sv
`timescale 1ns/1ns

module rx_sync (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [uart_pkg::NUM_CH-1:0] rx,   // Asynchronous serial lines
  output logic [uart_pkg::NUM_CH-1:0] rx_s  // Lines in the clk domain
);

  import uart_pkg::*;

  // One row of flops per stage, all lines side by side
  logic [NUM_CH-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      // Preset to idle so leaving reset never looks like a start bit
      for (int s = 0; s < SYNC_STAGES; s++) begin
        sync_q[s] <= '1;
      end
    end else begin
      sync_q[0] <= rx;  // First stage may go metastable
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // Last stage is settled
  assign rx_s = sync_q[SYNC_STAGES-1];

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 rx,    // Synchronized serial line
  output uart_pkg::rx_result_t res,   // Byte and framing error
  output logic                 done   // res valid, one cycle
);

  import uart_pkg::*;

  rx_state_t state_q;
  rx_state_t state_d;
  tic_cnt_t  tic_q;       // Bit timer
  bit_cnt_t  bit_cnt_q;   // Data bits taken so far
  byte_t     shreg_q;     // Shift register, LSB arrives first
  logic      half_tic;    // Middle of start bit
  logic      bit_tic;     // One full bit since last restart
  logic      tic_restart;

  assign half_tic = (tic_q == tic_cnt_t'(HALF_BIT - 1));
  assign bit_tic  = (tic_q == tic_cnt_t'(CLKS_PER_BIT - 1));

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (!rx) begin
          state_d = START;  // Falling edge seen
        end
      end
      START: begin
        if (half_tic) begin
          // High again at mid start bit means a glitch
          state_d = rx ? IDLE : DATA;
        end
      end
      DATA: begin
        if (bit_tic && (bit_cnt_q == bit_cnt_t'(7))) begin
          state_d = STOP;
        end
      end
      STOP: begin
        if (bit_tic) begin
          state_d = DONE;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Timer restarts on every state change and between data bits
  assign tic_restart = (state_d != state_q) || ((state_q == DATA) && bit_tic);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q   <= IDLE;
      tic_q     <= '0;
      bit_cnt_q <= '0;
    end else begin
      state_q <= state_d;

      if (tic_restart) begin
        tic_q <= '0;
      end else if (state_q != IDLE) begin
        tic_q <= tic_q + tic_cnt_t'(1);
      end

      // Wraps back to 0 after bit 7
      if (state_q == IDLE) begin
        bit_cnt_q <= '0;
      end else if ((state_q == DATA) && bit_tic) begin
        bit_cnt_q <= bit_cnt_q + bit_cnt_t'(1);
      end
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if ((state_q == DATA) && bit_tic) begin
      shreg_q <= {rx, shreg_q[7:1]};  // New bit enters at the top
    end
    if ((state_q == STOP) && bit_tic) begin
      res.data <= shreg_q;
      res.ferr <= ~rx;  // Stop bit must be high
    end
  end

  // Pulse in the cycle after the stop sample
  assign done = (state_q == DONE);

endmodule

// File: design/rx_collect.sv
`timescale 1ns/1ns

module rx_collect (
  input  logic                        clk,
  input  logic                        rstn,
  input  uart_pkg::rx_result_t        res [uart_pkg::NUM_CH],  // Receiver results
  input  logic [uart_pkg::NUM_CH-1:0] done,                    // Result strobes
  output uart_pkg::rx_event_t         evt,
  output logic                        evt_valid
);

  import uart_pkg::*;

  rx_result_t        hold_q [NUM_CH];  // One deep slot per channel
  logic [NUM_CH-1:0] pend_q;           // Slot holds an unsent result
  ch_idx_t           last_q;           // Channel served last
  ch_idx_t           sel;
  logic              sel_vld;

  // Round robin, search starts one past the last winner
  always_comb begin
    ch_idx_t cand;
    sel_vld = 1'b0;
    sel     = last_q;
    for (int k = 1; k <= NUM_CH; k++) begin
      cand = ch_idx_t'((int'(last_q) + k) % NUM_CH);
      if (!sel_vld && pend_q[cand]) begin
        sel_vld = 1'b1;
        sel     = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pend_q    <= '0;
      last_q    <= ch_idx_t'(NUM_CH - 1);  // Channel 0 goes first
      evt_valid <= 1'b0;
    end else begin
      evt_valid <= sel_vld;
      if (sel_vld) begin
        pend_q[sel] <= 1'b0;
        last_q      <= sel;
      end
      // A new result wins over the clear of the same slot
      for (int i = 0; i < NUM_CH; i++) begin
        if (done[i]) begin
          pend_q[i] <= 1'b1;
        end
      end
    end
  end

  // Slots and output payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (done[i]) begin
        hold_q[i] <= res[i];
      end
    end
    if (sel_vld) begin
      evt.ch   <= sel;
      evt.data <= hold_q[sel].data;
      evt.ferr <= hold_q[sel].ferr;
    end
  end

endmodule

// File: design/uart_rx_bank.sv
`timescale 1ns/1ns

module uart_rx_bank (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic [uart_pkg::NUM_CH-1:0] rx,        // Serial lines, idle high
  output uart_pkg::rx_event_t         evt,       // Tagged byte
  output logic                        evt_valid  // evt strobe
);

  import uart_pkg::*;

  logic [NUM_CH-1:0] rx_s;             // Synchronized lines
  rx_result_t        rx_res [NUM_CH];  // Per channel result
  logic [NUM_CH-1:0] rx_done;          // Per channel result strobe

  rx_sync u_sync (
    .clk  (clk),
    .rstn (rstn),
    .rx   (rx),
    .rx_s (rx_s)
  );

  // One receiver per line
  for (genvar i = 0; i < NUM_CH; i++) begin : g_rx
    uart_rx u_rx (
      .clk  (clk),
      .rstn (rstn),
      .rx   (rx_s[i]),
      .res  (rx_res[i]),
      .done (rx_done[i])
    );
  end

  // Merge into one event stream
  rx_collect u_collect (
    .clk       (clk),
    .rstn      (rstn),
    .res       (rx_res),
    .done      (rx_done),
    .evt       (evt),
    .evt_valid (evt_valid)
  );

endmodule

// File: tests/uart_rx_bank_sva.sv
`timescale 1ns/1ns

module uart_rx_bank_sva (
  input logic                        clk,
  input logic                        rstn,
  input uart_pkg::rx_event_t         evt,
  input logic                        evt_valid,
  input logic [uart_pkg::NUM_CH-1:0] rx_done  // Receiver strobes inside the bank
);

  import uart_pkg::*;

  int n_fail = 0;  // Failed assertion count

  // Output strobe is a clean level once out of reset
  a_valid_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(evt_valid))
    else begin
      $error("evt_valid is unknown");
      n_fail++;
    end

  // Each receiver pulses done for exactly one cycle
  for (genvar i = 0; i < NUM_CH; i++) begin : g_done
    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) rx_done[i] |=> !rx_done[i])
      else begin
        $error("done of channel %0d high for more than one cycle", i);
        n_fail++;
      end
  end

  // Valid event names a real channel and carries a loaded slot
  a_ch_range: assert property (@(posedge clk) disable iff (!rstn)
                               evt_valid |-> (!$isunknown(evt) && (int'(evt.ch) < NUM_CH)))
    else begin
      $error("evt %0h has a bad channel or an unknown payload", evt);
      n_fail++;
    end

endmodule

bind uart_rx_bank uart_rx_bank_sva i_sva (
  .clk       (clk),
  .rstn      (rstn),
  .evt       (evt),
  .evt_valid (evt_valid),
  .rx_done   (rx_done)
);

// File: tests/uart_rx_bank_tb.sv
`timescale 1ns/1ns

module uart_rx_bank_tb;

  import uart_pkg::*;

  localparam int N_BURST   = 6;                  // Back to back frames per channel
  localparam int FRAME_CLK = 10 * CLKS_PER_BIT;  // Start, 8 data, stop
  localparam int GLITCH    = HALF_BIT / 2;       // Too short to pass the start check

  logic              clk;
  logic              rstn;
  logic [NUM_CH-1:0] rx;
  rx_event_t         evt;
  logic              evt_valid;

  rx_event_t exp_q [NUM_CH][$];        // Expected events per channel, oldest first
  int        n_sent;                   // Frames queued for checking
  int        n_events;                 // Events seen on the output
  int        n_drv_done;               // Parallel drivers finished
  int        solo_ch;                  // Only driven line, -1 when all lines run
  int        seed;
  string     test_name;
  byte_t     burst [NUM_CH][N_BURST];  // Random bytes for the parallel test

  uart_rx_bank i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .rx        (rx),
    .evt       (evt),
    .evt_valid (evt_valid)
  );

  always #10 clk = ~clk;  // 20 ns period

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(input byte_t want, input byte_t got);
    if (got !== want) begin
      $display("CHECK FAILED %s data: expected %02h actual %02h", test_name, want, got);
      abort_run();
    end
  endtask

  task automatic check_ch(input ch_idx_t want, input ch_idx_t got);
    if (got !== want) begin
      $display("CHECK FAILED %s ch: expected %0d actual %0d", test_name, want, got);
      abort_run();
    end
  endtask

  task automatic check_ferr(input logic want, input logic got);
    if (got !== want) begin
      $display("CHECK FAILED %s ferr: expected %0b actual %0b", test_name, want, got);
      abort_run();
    end
  endtask

  // Event the bank should produce for one sent frame
  function automatic rx_event_t expected_event(input int ch, input byte_t data,
                                               input logic stop_bit);
    rx_event_t e;
    e.ch   = ch_idx_t'(ch);
    e.data = data;
    e.ferr = (stop_bit == 1'b0);  // Low stop bit is a framing error
    return e;
  endfunction

  // One 8N1 frame, line changes on falling edges only
  task automatic send_frame(input int ch, input byte_t data, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};  // Start bit goes out first, then LSB
    exp_q[ch].push_back(expected_event(ch, data, stop_bit));
    n_sent++;
    @(negedge clk);
    for (int b = 0; b < 10; b++) begin
      rx[ch] = bits[b];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    if (!stop_bit) begin
      rx[ch] = 1'b1;  // Back to idle for one bit
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // Short low pulse that must not start a frame
  task automatic send_glitch(input int ch, input int len);
    @(negedge clk);
    rx[ch] = 1'b0;
    repeat (len) @(negedge clk);
    rx[ch] = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);  // Receiver falls back to IDLE
  endtask

  task automatic wait_events(input int target, input int max_cycles);
    int cyc;
    cyc = 0;
    while (n_events < target) begin
      @(posedge clk);
      cyc++;
      if (cyc > max_cycles) begin
        $display("Timeout in %s: %0d of %0d events arrived", test_name, n_events, target);
        abort_run();
      end
    end
  endtask

  task automatic wait_drivers(input int target, input int max_cycles);
    int cyc;
    cyc = 0;
    while (n_drv_done < target) begin
      @(posedge clk);
      cyc++;
      if (cyc > max_cycles) begin
        $display("Timeout in %s: only %0d line drivers finished", test_name, n_drv_done);
        abort_run();
      end
    end
  endtask

  // Scoreboard, evt is stable at the falling edge
  always @(negedge clk) begin
    rx_event_t want;
    int        q_idx;
    if (rstn && evt_valid) begin
      q_idx = (solo_ch >= 0) ? solo_ch : int'(evt.ch);  // Driven line when only one runs
      if (exp_q[q_idx].size() == 0) begin
        $display("Event on channel %0d with data %02h was not expected", evt.ch, evt.data);
        abort_run();
      end else begin
        want = exp_q[q_idx].pop_front();
        check_ch(want.ch, evt.ch);
        check_byte(want.data, evt.data);
        check_ferr(want.ferr, evt.ferr);
        n_events++;
      end
    end
  end

  initial begin
    clk        = 1'b0;
    rstn       = 1'b0;
    rx         = '1;  // All lines idle
    n_sent     = 0;
    n_events   = 0;
    n_drv_done = 0;
    solo_ch    = -1;
    seed       = 32'h7adcb1e3;
    test_name  = "reset";
    repeat (10) @(negedge clk);
    rstn = 1'b1;

    // Any event while idle finds an empty queue
    test_name = "idle";
    repeat (20 * CLKS_PER_BIT) @(negedge clk);

    test_name = "single";
    for (int c = 0; c < NUM_CH; c++) begin
      solo_ch = c;
      send_frame(c, byte_t'($random(seed)), 1'b1);
      wait_events(n_sent, 2 * CLKS_PER_BIT);
    end

    // All channels start together, frames back to back
    test_name = "burst";
    solo_ch   = -1;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int r = 0; r < N_BURST; r++) begin
        burst[c][r] = byte_t'($random(seed));
      end
    end
    n_drv_done = 0;
    for (int c = 0; c < NUM_CH; c++) begin
      fork
        automatic int cc = c;
        begin
          for (int r = 0; r < N_BURST; r++) begin
            send_frame(cc, burst[cc][r], 1'b1);
          end
          n_drv_done++;
        end
      join_none
    end
    wait_drivers(NUM_CH, (N_BURST + 1) * FRAME_CLK);
    wait_events(n_sent, 2 * CLKS_PER_BIT);

    test_name = "framing";
    for (int c = 0; c < NUM_CH; c++) begin
      solo_ch = c;
      send_frame(c, byte_t'($random(seed)), 1'b0);  // Stop bit low
      wait_events(n_sent, 2 * CLKS_PER_BIT);
    end

    test_name = "glitch";
    for (int c = 0; c < NUM_CH; c++) begin
      solo_ch = c;
      send_glitch(c, GLITCH);
      send_frame(c, byte_t'($random(seed)), 1'b1);
      wait_events(n_sent, 2 * CLKS_PER_BIT);
    end

    // Quiet tail to catch stray events
    test_name = "final";
    solo_ch   = -1;
    repeat (4 * CLKS_PER_BIT) @(negedge clk);
    for (int c = 0; c < NUM_CH; c++) begin
      if (exp_q[c].size() != 0) begin
        $display("Channel %0d still has %0d events outstanding", c, exp_q[c].size());
        abort_run();
      end
    end
    if (i_dut.i_sva.n_fail != 0) begin
      $display("%0d assertion failures", i_dut.i_sva.n_fail);
      abort_run();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: uart_rx_bank.f
design/uart_pkg.sv
design/rx_sync.sv
design/uart_rx.sv
design/rx_collect.sv
design/uart_rx_bank.sv
tests/uart_rx_bank_sva.sv
tests/uart_rx_bank_tb.sv
